//--- common/modarith_pkg.sv
package modarith_pkg;

	// ====================
	// Widths and defaults

	localparam int OP_W = 2;

	localparam int DEF_N = 64;     // Operand width
	localparam int DEF_WORD = 16;  // Word width of the partial products and the adder

	// Largest 64-bit prime, 2^64 - 59
	localparam logic [63:0] DEF_P = 64'hFFFF_FFFF_FFFF_FFC5;

	// ====================
	// Operation codes

	// Same encodings as the full prime-field unit
	typedef enum logic [OP_W-1:0] {
		OP_MONT = 2'b00,  // Montgomery product, not built here
		OP_ADD  = 2'b01,
		OP_SUB  = 2'b10,
		OP_MUL  = 2'b11   // Full 2N-bit product
	} op_t;

endpackage

//--- common/unit_if.sv
`timescale 1ns/10ps

// Command and completion path between the sequencer and one arithmetic unit
interface unit_if import modarith_pkg::*; #(
	parameter int N = DEF_N
) ();

	logic start;             // One-cycle strobe, only while the unit is idle
	logic [N-1:0] a;
	logic [N-1:0] b;
	logic sub_mode;          // Subtract in the add/sub unit
	logic done;              // One-cycle strobe, result valid
	logic [2*N-1:0] result;

	modport ctrl (
		output start, a, b, sub_mode,
		input done, result
	);

	modport unit (
		input start, a, b, sub_mode,
		output done, result
	);

endinterface

//--- addsub/carry_select_addsub.sv
`timescale 1ns/10ps

module carry_select_addsub #(
	parameter int N = 64,
	parameter int WORD = 16
) (
	input logic clk,
	input logic rst,
	unit_if.unit bus
);

	localparam int WORDS = N / WORD;

	logic [WORD:0] cand0 [WORDS];  // Plain sum or difference, top bit carry/borrow
	logic [WORD:0] cand1 [WORDS];  // Same with carry-in (or borrow-in) of one
	logic sel_pending;
	logic [N-1:0] sel_val;
	logic [WORDS:0] cy;

	// ====================
	// Cycle 1, per-word candidates
	always_ff @(posedge clk) begin : cand_regs
		logic [WORD:0] aw;
		logic [WORD:0] bw;
		if (bus.start) begin
			for (int i = 0; i < WORDS; i++) begin
				aw = {1'b0, bus.a[i*WORD +: WORD]};
				bw = {1'b0, bus.b[i*WORD +: WORD]};
				if (bus.sub_mode) begin
					cand0[i] <= aw - bw;
					cand1[i] <= aw - bw - 1'b1;
				end else begin
					cand0[i] <= aw + bw;
					cand1[i] <= aw + bw + 1'b1;
				end
			end
		end
	end

	// ====================
	// Cycle 2, carry chain picks a candidate per word
	always_comb begin
		cy[0] = 1'b0;
		for (int i = 0; i < WORDS; i++) begin
			sel_val[i*WORD +: WORD] = cy[i] ? cand1[i][WORD-1:0] : cand0[i][WORD-1:0];
			cy[i+1] = cy[i] ? cand1[i][WORD] : cand0[i][WORD];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_pending <= 1'b0;
			bus.done <= 1'b0;
		end else begin
			sel_pending <= bus.start;
			bus.done <= sel_pending;
		end
	end

	always_ff @(posedge clk) begin
		if (sel_pending)
			bus.result <= {{(N-1){1'b0}}, cy[WORDS], sel_val};  // Bit N is carry or borrow
	end

	done_two_after_start: assert property (@(posedge clk) disable iff (rst)
		bus.start |-> ##2 bus.done);

endmodule

//--- multiplier/word_serial_mul.sv
`timescale 1ns/10ps

module word_serial_mul #(
	parameter int N = 64,
	parameter int WORD = 16
) (
	input logic clk,
	input logic rst,
	unit_if.unit bus
);

	localparam int WORDS = N / WORD;
	localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

	logic [N-1:0] a_reg;
	logic [N-1:0] b_reg;
	logic [IDX_W-1:0] idx;      // Word of b fed to the row
	logic [IDX_W-1:0] row_idx;  // Word position of the registered row
	logic busy;
	logic row_vld;
	logic [WORD-1:0] b_word;
	logic [2*WORD-1:0] part [WORDS];
	logic [N+WORD-1:0] row;
	logic [N+WORD-1:0] row_reg;
	logic [2*N-1:0] row_ext;
	logic [2*N-1:0] acc;

	assign b_word = b_reg[idx*WORD +: WORD];

	// ====================
	// Row of word multipliers, a times one word of b
	for (genvar j = 0; j < WORDS; j++) begin : g_word_mul
		assign part[j] = a_reg[j*WORD +: WORD] * b_word;
	end

	always_comb begin
		row = '0;
		for (int j = 0; j < WORDS; j++)
			row = row + ({{(N-WORD){1'b0}}, part[j]} << (j*WORD));
	end

	assign row_ext = {{(N-WORD){1'b0}}, row_reg} << (row_idx*WORD);
	assign bus.result = acc;

	// ====================
	// Control
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			row_vld <= 1'b0;
			idx <= '0;
			bus.done <= 1'b0;
		end else begin
			bus.done <= row_vld && !busy;  // Last row accumulating
			if (bus.start) begin
				busy <= 1'b1;
				row_vld <= 1'b0;
				idx <= '0;
			end else begin
				row_vld <= busy;
				if (busy) begin
					idx <= idx + 1'b1;
					if (idx == IDX_W'(WORDS-1))
						busy <= 1'b0;
				end
			end
		end
	end

	// Operand load, row pipeline register and accumulator
	always_ff @(posedge clk) begin
		if (bus.start) begin
			a_reg <= bus.a;
			b_reg <= bus.b;
			acc <= '0;
		end else if (row_vld) begin
			acc <= acc + row_ext;
		end
		if (busy) begin
			row_reg <= row;
			row_idx <= idx;
		end
	end

	start_when_idle: assert property (@(posedge clk) disable iff (rst)
		bus.start |-> !(busy || row_vld));

endmodule

//--- src/op_sequencer.sv
`timescale 1ns/10ps

module op_sequencer import modarith_pkg::*; #(
	parameter int N = DEF_N,
	parameter logic [N-1:0] P = DEF_P
) (
	input logic clk,
	input logic rst,
	input logic req,
	input op_t op,
	input logic [N-1:0] a,
	input logic [N-1:0] b,
	output logic ack,
	output logic [2*N-1:0] result,
	unit_if.ctrl as_bus,
	unit_if.ctrl mul_bus
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FIRST,     // First unit pass running
		ST_CORR,      // Adding or subtracting P
		ST_ACK,
		ST_WAIT_LOW
	} state_t;

	state_t state;
	op_t op_q;
	logic [N-1:0] as_val;
	logic as_over;

	assign as_val = as_bus.result[N-1:0];

	// Sum out of range, or difference went negative
	assign as_over = (op_q == OP_ADD) ? (as_bus.result[N] || as_val >= P) : as_bus.result[N];

	assign mul_bus.sub_mode = 1'b0;

	// ====================
	// Operation FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			ack <= 1'b0;
			as_bus.start <= 1'b0;
			mul_bus.start <= 1'b0;
		end else begin
			as_bus.start <= 1'b0;
			mul_bus.start <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req) begin
						op_q <= op;
						case (op)
							OP_ADD, OP_SUB: begin
								as_bus.start <= 1'b1;
								as_bus.a <= a;
								as_bus.b <= b;
								as_bus.sub_mode <= (op == OP_SUB);
								state <= ST_FIRST;
							end
							OP_MUL: begin
								mul_bus.start <= 1'b1;
								mul_bus.a <= a;
								mul_bus.b <= b;
								state <= ST_FIRST;
							end
							default: begin  // Montgomery dropped, answer zero at once
								result <= '0;
								ack <= 1'b1;
								state <= ST_ACK;
							end
						endcase
					end
				end
				ST_FIRST: begin
					if (op_q == OP_MUL) begin
						if (mul_bus.done) begin
							result <= mul_bus.result;
							ack <= 1'b1;
							state <= ST_ACK;
						end
					end else if (as_bus.done) begin
						if (as_over) begin
							as_bus.start <= 1'b1;
							as_bus.a <= as_val;
							as_bus.b <= P;
							as_bus.sub_mode <= (op_q == OP_ADD);  // Opposite of first pass
							state <= ST_CORR;
						end else begin
							result <= {{N{1'b0}}, as_val};
							ack <= 1'b1;
							state <= ST_ACK;
						end
					end
				end
				ST_CORR: begin
					if (as_bus.done) begin
						result <= {{N{1'b0}}, as_val};  // Wrap bit dropped
						ack <= 1'b1;
						state <= ST_ACK;
					end
				end
				default: begin
					if (!req) begin
						ack <= 1'b0;
						state <= ST_IDLE;
					end else begin
						state <= ST_WAIT_LOW;  // Back-pressure, hold ack and result
					end
				end
			endcase
		end
	end

	// ====================
	// Checks
	op_not_mont: assert property (@(posedge clk) disable iff (rst) req |-> op != OP_MONT)
		else $warning("Montgomery op requested, returning zero");

	ack_needs_req: assert property (@(posedge clk) disable iff (rst) (!req && !ack) |=> !ack);

	// One add/sub pass at a time
	as_one_pass: assert property (@(posedge clk) disable iff (rst)
		as_bus.start |=> (!as_bus.start until_with as_bus.done));

endmodule

//--- src/modarith_top.sv
`timescale 1ns/10ps

module modarith_top import modarith_pkg::*; #(
	parameter int N = DEF_N,
	parameter int WORD = DEF_WORD,
	parameter logic [N-1:0] P = DEF_P
) (
	input logic clk,
	input logic rst,
	input logic req,
	input op_t op,
	input logic [N-1:0] a,
	input logic [N-1:0] b,
	output logic ack,
	output logic [2*N-1:0] result
);

	unit_if #(.N(N)) as_bus ();   // Sequencer to carry-select add/sub
	unit_if #(.N(N)) mul_bus ();  // Sequencer to word-serial multiplier

	op_sequencer #(
		.N(N),
		.P(P)
	) u_op_sequencer (
		.clk(clk),
		.rst(rst),
		.req(req),
		.op(op),
		.a(a),
		.b(b),
		.ack(ack),
		.result(result),
		.as_bus(as_bus),
		.mul_bus(mul_bus)
	);

	carry_select_addsub #(
		.N(N),
		.WORD(WORD)
	) u_carry_select_addsub (
		.clk(clk),
		.rst(rst),
		.bus(as_bus)
	);

	word_serial_mul #(
		.N(N),
		.WORD(WORD)
	) u_word_serial_mul (
		.clk(clk),
		.rst(rst),
		.bus(mul_bus)
	);

endmodule

//--- sim/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns are op, a, b and the expected result
// P is 64'hFFFF_FFFF_FFFF_FFC5

localparam int FIXED_ROWS = 18;

task automatic load_fixed_rows();
	// Full products
	add_row(OP_MUL, 64'h0, 64'h1234, 128'h0);
	add_row(OP_MUL, 64'h1, 64'hDEAD_BEEF_0123_4567, 128'hDEAD_BEEF_0123_4567);
	add_row(OP_MUL, 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF,
		128'hFFFF_FFFF_FFFF_FFFE_0000_0000_0000_0001);
	add_row(OP_MUL, 64'h0000_0001_0000_0000, 64'h0000_0001_0000_0000,
		128'h0000_0000_0000_0001_0000_0000_0000_0000);
	add_row(OP_MUL, 64'h0123_4567_89AB_CDEF, 64'h10, 128'h1234_5678_9ABC_DEF0);
	add_row(OP_MUL, 64'hFFFF, 64'hFFFF_0000_0000_0000,
		128'h0000_0000_0000_FFFE_0001_0000_0000_0000);

	// Modular sums
	add_row(OP_ADD, 64'h1, 64'h2, 128'h3);
	add_row(OP_ADD, 64'hFFFF_FFFF_FFFF_FFC4, 64'h1, 128'h0);             // Sum is P
	add_row(OP_ADD, 64'hFFFF_FFFF_FFFF_FFC0, 64'h10, 128'hB);            // Above P, no carry
	add_row(OP_ADD, 64'hFFFF_FFFF_FFFF_FFC4, 64'hFFFF_FFFF_FFFF_FFC4,
		128'hFFFF_FFFF_FFFF_FFC3);
	add_row(OP_ADD, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 128'h3B);
	add_row(OP_ADD, 64'h00FF_FFFF_FFFF_FFFF, 64'h1, 128'h0100_0000_0000_0000);

	// Modular differences
	add_row(OP_SUB, 64'h5, 64'h3, 128'h2);
	add_row(OP_SUB, 64'h3, 64'h5, 128'hFFFF_FFFF_FFFF_FFC3);
	add_row(OP_SUB, 64'h1234, 64'h1234, 128'h0);
	add_row(OP_SUB, 64'h0, 64'hFFFF_FFFF_FFFF_FFC4, 128'h1);
	add_row(OP_SUB, 64'hFFFF_FFFF_FFFF_FFC4, 64'h0, 128'hFFFF_FFFF_FFFF_FFC4);
	add_row(OP_SUB, 64'h0001_0000_0000_0000, 64'h1, 128'h0000_FFFF_FFFF_FFFF);  // Borrow chain
endtask

`endif

//--- sim/tb_modarith.sv
`timescale 1ns/10ps

module tb_modarith import modarith_pkg::*; ();

	localparam int N = DEF_N;
	localparam int WORDS = DEF_N / DEF_WORD;
	localparam logic [N-1:0] P = DEF_P;

	`include "tb_vectors.svh"

	localparam int RANDOM_ROWS = 30;
	localparam int TOTAL_ROWS = FIXED_ROWS + RANDOM_ROWS;
	localparam int CYCLE_LIMIT = TOTAL_ROWS * (WORDS + 20);

	logic clk;
	logic rst;
	logic req;
	op_t op;
	logic [N-1:0] a;
	logic [N-1:0] b;
	logic ack;
	logic [2*N-1:0] result;

	op_t vec_op [TOTAL_ROWS];
	logic [N-1:0] vec_a [TOTAL_ROWS];
	logic [N-1:0] vec_b [TOTAL_ROWS];
	logic [2*N-1:0] vec_exp [TOTAL_ROWS];
	int row_count = 0;

	int mismatches = 0;
	int hs_errors = 0;   // Handshake failures
	int ack_rises = 0;
	int cycles = 0;
	logic ack_prev = 1'b0;
	logic req_at_edge = 1'b0;  // req as the DUT saw it at the last rising edge

	modarith_top u_modarith_top (
		.clk(clk),
		.rst(rst),
		.req(req),
		.op(op),
		.a(a),
		.b(b),
		.ack(ack),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ====================
	// Table building and reference rules
	task automatic add_row(input op_t row_op, input logic [N-1:0] row_a,
		input logic [N-1:0] row_b, input logic [2*N-1:0] row_exp);
		vec_op[row_count] = row_op;
		vec_a[row_count] = row_a;
		vec_b[row_count] = row_b;
		vec_exp[row_count] = row_exp;
		row_count++;
	endtask

	function automatic logic [N-1:0] reduce_below_p(input logic [N-1:0] v);
		reduce_below_p = (v >= P) ? v - P : v;
	endfunction

	function automatic logic [2*N-1:0] expected_result(input op_t f_op,
		input logic [N-1:0] x, input logic [N-1:0] y);
		logic [N:0] sum;
		logic [2*N-1:0] res;
		res = '0;
		case (f_op)
			OP_MUL: res = {{N{1'b0}}, x} * {{N{1'b0}}, y};
			OP_ADD: begin
				sum = {1'b0, x} + {1'b0, y};
				if (sum >= {1'b0, P})
					sum = sum - {1'b0, P};
				res = {{N{1'b0}}, sum[N-1:0]};
			end
			OP_SUB: res = (x >= y) ? {{N{1'b0}}, x - y} : {{N{1'b0}}, x + (P - y)};
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic add_random_rows();
		op_t r_op;
		logic [N-1:0] r_a;
		logic [N-1:0] r_b;
		for (int k = 0; k < RANDOM_ROWS; k++) begin
			r_op = op_t'(($urandom % 3) + 1);  // ADD, SUB or MUL
			r_a = reduce_below_p({$urandom, $urandom});
			r_b = reduce_below_p({$urandom, $urandom});
			add_row(r_op, r_a, r_b, expected_result(r_op, r_a, r_b));
		end
	endtask

	// ====================
	// Checking and handshake driver
	task automatic check_value(input string name, input logic [2*N-1:0] got,
		input logic [2*N-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic run_row(input int idx);
		int hold;
		logic [2*N-1:0] held;
		hold = idx % 3;  // Extra cycles of req after ack
		req = 1'b1;
		op = vec_op[idx];
		a = vec_a[idx];
		b = vec_b[idx];
		@(negedge clk);
		while (ack !== 1'b1)
			@(negedge clk);
		check_value($sformatf("result row %0d", idx), result, vec_exp[idx]);
		held = result;
		repeat (hold) begin
			@(negedge clk);
			if (ack !== 1'b1) begin
				$display("Row %0d: ack dropped while req was still high", idx);
				hs_errors++;
			end
			if (result !== held) begin
				$display("Row %0d: result changed while ack was high", idx);
				hs_errors++;
			end
		end
		req = 1'b0;
		@(negedge clk);
		while (ack !== 1'b0)
			@(negedge clk);
		if (result !== held) begin
			$display("Row %0d: result did not hold after ack fell", idx);
			hs_errors++;
		end
	endtask

	always @(posedge clk)
		req_at_edge = req;

	// Counts acknowledgements so a lost or extra one shows at the end
	always @(negedge clk) begin
		if (!rst && ack && !ack_prev) begin
			ack_rises++;
			if (!req_at_edge) begin
				$display("ack rose while req was low");
				hs_errors++;
			end
		end
		ack_prev = ack;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, a handshake never completed", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ====================
	// Main sequence
	initial begin
		int seed_init;
		seed_init = $urandom(72);
		rst = 1'b1;
		req = 1'b0;
		op = OP_ADD;
		a = '0;
		b = '0;
		load_fixed_rows();
		add_random_rows();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		if (ack !== 1'b0) begin
			$display("ack is not low after reset");
			hs_errors++;
		end
		for (int i = 0; i < TOTAL_ROWS; i++)
			run_row(i);
		repeat (3) @(negedge clk);
		if (ack_rises != TOTAL_ROWS) begin
			$display("Saw %0d acknowledgements for %0d requests", ack_rises, TOTAL_ROWS);
			hs_errors++;
		end
		$display("Errors: %0d mismatches, %0d handshake failures", mismatches, hs_errors);
		if (mismatches == 0 && hs_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+sim
common/modarith_pkg.sv
common/unit_if.sv
addsub/carry_select_addsub.sv
multiplier/word_serial_mul.sv
src/op_sequencer.sv
src/modarith_top.sv
sim/tb_modarith.sv
